// ==== dv/input_pipe_tb.sv ====
`timescale 1ns/1ps
`include "input_pipe_macros.svh"

module input_pipe_tb;

  localparam int PIX_BITS  = `UNITS * `WORD_WIDTH;
  localparam int WT_BITS   = `CORES * `WORD_WIDTH;
  localparam int BEAT_BITS = PIX_BITS + WT_BITS + 3;

  // Pixel beats and weight beats (config beat included) over all tests.
  localparam int PIX_BEATS = 8 + 4 + 16 + 6 + 12 + 10 + 6;
  localparam int WT_BEATS  = (4 + 1) + (1 + 1) + (8 + 1) + (2 + 1) + (3 + 1) + (5 + 1) + (2 + 1);
  localparam int TIMEOUT_CYCLES = 4 * (PIX_BEATS + WT_BEATS) + 500;

  // Packed as {pix, wt, user, last}.
  typedef logic [BEAT_BITS-1:0] beat_t;

  logic                      aclk;
  logic                      i_rst_n;
  logic                      i_s_pix_valid;
  logic                      o_s_pix_ready;
  input_pipe_pkg::pix_beat_t i_s_pix_data;
  logic                      i_s_pix_last;
  logic                      i_s_wt_valid;
  logic                      o_s_wt_ready;
  input_pipe_pkg::wt_beat_t  i_s_wt_data;
  logic                      i_s_wt_last;
  logic                      o_m_valid;
  logic                      i_m_ready;
  input_pipe_pkg::pix_beat_t o_m_pix;
  input_pipe_pkg::wt_beat_t  o_m_wt;
  input_pipe_pkg::tuser_t    o_m_user;
  logic                      o_m_last;

  input_pipe_pkg::pix_beat_t pix_q [$];
  logic                      pix_last_q [$];
  input_pipe_pkg::wt_beat_t  wt_q [$];
  logic                      wt_last_q [$];
  beat_t                     exp_q [$];
  input_pipe_pkg::wt_beat_t  wt_tab [`CIN_MAX];  // Weights of the image being built.

  logic [31:0] rng_state;
  logic [31:0] bp_rand;
  logic        bp_on;
  logic        gaps_on;
  int          errors;
  int          checks;
  int          tests;
  int          failed;
  int          out_count;
  int          cycles;
  beat_t       got_beat;
  beat_t       exp_beat;

  axis_input_pipe uut (
    .aclk          (aclk),
    .i_rst_n       (i_rst_n),
    .i_s_pix_valid (i_s_pix_valid),
    .o_s_pix_ready (o_s_pix_ready),
    .i_s_pix_data  (i_s_pix_data),
    .i_s_pix_last  (i_s_pix_last),
    .i_s_wt_valid  (i_s_wt_valid),
    .o_s_wt_ready  (o_s_wt_ready),
    .i_s_wt_data   (i_s_wt_data),
    .i_s_wt_last   (i_s_wt_last),
    .o_m_valid     (o_m_valid),
    .i_m_ready     (i_m_ready),
    .o_m_pix       (o_m_pix),
    .o_m_wt        (o_m_wt),
    .o_m_user      (o_m_user),
    .o_m_last      (o_m_last)
  );

  always #20 aclk = ~aclk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected output beat n of an image with npix beats and cin channels.
  function automatic beat_t ref_beat(input input_pipe_pkg::pix_beat_t pix, input int n,
                                     input int npix, input int cin);
    int   ch;
    logic cin_last;
    logic first;
    ch       = n % cin;
    cin_last = (ch == cin - 1);
    first    = (n == 0);
    return {pix, wt_tab[ch], first, cin_last, (n == npix - 1)};
  endfunction

  task automatic build_image(input int npix, input int cin);
    input_pipe_pkg::pix_beat_t p;
    input_pipe_pkg::wt_beat_t  w;
    logic [31:0]               r;
    r = next_rand();
    w = r[WT_BITS-1:0];
    w[0][`BITS_CIN-1:0] = input_pipe_pkg::cin_t'(cin);  // Config beat.
    wt_q.push_back(w);
    wt_last_q.push_back(1'b0);
    for (int n = 0; n < cin; n++) begin
      r = next_rand();
      wt_tab[n] = r[WT_BITS-1:0];
      wt_q.push_back(wt_tab[n]);
      wt_last_q.push_back(n == cin - 1);
    end
    for (int n = 0; n < npix; n++) begin
      r = next_rand();
      p = r[PIX_BITS-1:0];
      pix_q.push_back(p);
      pix_last_q.push_back(n == npix - 1);
      exp_q.push_back(ref_beat(p, n, npix, cin));
    end
  endtask

  // Entered and left 2 ns after a rising edge.
  task automatic idle_gap();
    logic [31:0] r;
    int          gap;
    if (gaps_on) begin
      r   = next_rand();
      gap = r % 4;
      if (gap > 0) begin
        repeat (gap) @(posedge aclk);
        #2;
      end
    end
  endtask

  task automatic drive_pixels();
    while (pix_q.size() > 0) begin
      idle_gap();
      i_s_pix_valid = 1'b1;
      i_s_pix_data  = pix_q.pop_front();
      i_s_pix_last  = pix_last_q.pop_front();
      @(posedge aclk);
      while (!o_s_pix_ready) @(posedge aclk);
      #2;
      i_s_pix_valid = 1'b0;
    end
  endtask

  task automatic drive_weights();
    while (wt_q.size() > 0) begin
      idle_gap();
      i_s_wt_valid = 1'b1;
      i_s_wt_data  = wt_q.pop_front();
      i_s_wt_last  = wt_last_q.pop_front();
      @(posedge aclk);
      while (!o_s_wt_ready) @(posedge aclk);
      #2;
      i_s_wt_valid = 1'b0;
    end
  endtask

  task automatic run_test(input string name, input int wt_delay);
    int err_start;
    int nbeats;
    err_start = errors;
    nbeats    = exp_q.size();
    out_count = 0;
    fork
      drive_pixels();
      begin
        // Nothing may leave before the weights are in.
        repeat (wt_delay) begin
          @(posedge aclk);
          if (o_m_valid) begin
            $display("Output valid at %0t before any weights were sent", $time);
            errors++;
          end
        end
        if (wt_delay > 0) #2;
        drive_weights();
      end
    join
    while (exp_q.size() > 0) @(posedge aclk);
    @(posedge aclk);
    #2;
    tests++;
    if (errors == err_start) begin
      $display("test %s: ok, %0d beats", name, nbeats);
    end else begin
      failed++;
      $display("test %s: failed, %0d errors", name, errors - err_start);
    end
  endtask

  always @(posedge aclk) begin
    #2;
    if (bp_on) begin
      bp_rand   = next_rand();
      i_m_ready = bp_rand[31];
    end else begin
      i_m_ready = 1'b1;
    end
  end

  always @(posedge aclk) begin
    if (i_rst_n && o_m_valid && i_m_ready) begin
      got_beat = {o_m_pix, o_m_wt, o_m_user, o_m_last};
      if (exp_q.size() == 0) begin
        $display("Unexpected output beat at %0t: %h", $time, got_beat);
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        checks++;
        if (got_beat !== exp_beat) begin
          // Fields shown as pix/wt/user/last.
          $display("Mismatch at %0t: beat %0d expected %h/%h/%b/%b got %h/%h/%b/%b",
                   $time, out_count,
                   exp_beat[WT_BITS+3 +: PIX_BITS], exp_beat[3 +: WT_BITS],
                   exp_beat[1 +: 2], exp_beat[0],
                   got_beat[WT_BITS+3 +: PIX_BITS], got_beat[3 +: WT_BITS],
                   got_beat[1 +: 2], got_beat[0]);
          errors++;
        end
      end
      out_count++;
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    aclk          = 1'b0;
    i_rst_n       = 1'b0;
    i_s_pix_valid = 1'b0;
    i_s_pix_data  = '0;
    i_s_pix_last  = 1'b0;
    i_s_wt_valid  = 1'b0;
    i_s_wt_data   = '0;
    i_s_wt_last   = 1'b0;
    i_m_ready     = 1'b0;
    rng_state     = 32'hf4be_30e1;
    bp_rand       = '0;
    bp_on         = 1'b0;
    gaps_on       = 1'b0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    failed        = 0;
    out_count     = 0;
    cycles        = 0;
    repeat (10) @(posedge aclk);
    #2;
    i_rst_n = 1'b1;

    build_image(8, 4);
    run_test("basic image", 0);

    build_image(4, 1);
    run_test("cin of one", 0);
    build_image(16, `CIN_MAX);
    run_test("cin of max", 0);

    build_image(6, 2);
    run_test("late weights", 20);  // FIFO fills while the rotator waits.

    bp_on   = 1'b1;
    gaps_on = 1'b1;
    build_image(12, 3);
    run_test("back-pressure", 0);
    bp_on   = 1'b0;
    gaps_on = 1'b0;

    build_image(10, 5);
    build_image(6, 2);
    run_test("back-to-back images", 0);

    repeat (5) @(posedge aclk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/input_pipe_pkg.sv
hdl/pixel_fifo.sv
hdl/weight_rotator.sv
hdl/beat_joiner.sv
hdl/axis_input_pipe.sv
dv/input_pipe_tb.sv

// ==== hdl/axis_input_pipe.sv ====
`timescale 1ns/1ps

module axis_input_pipe (
  input  logic                      aclk,
  input  logic                      i_rst_n,

  input  logic                      i_s_pix_valid,
  output logic                      o_s_pix_ready,
  input  input_pipe_pkg::pix_beat_t i_s_pix_data,
  input  logic                      i_s_pix_last,

  input  logic                      i_s_wt_valid,
  output logic                      o_s_wt_ready,
  input  input_pipe_pkg::wt_beat_t  i_s_wt_data,
  input  logic                      i_s_wt_last,

  output logic                      o_m_valid,
  input  logic                      i_m_ready,
  output input_pipe_pkg::pix_beat_t o_m_pix,
  output input_pipe_pkg::wt_beat_t  o_m_wt,
  output input_pipe_pkg::tuser_t    o_m_user,
  output logic                      o_m_last
);

  logic                      pix_valid;
  logic                      pix_ready;
  input_pipe_pkg::pix_beat_t pix_data;
  logic                      pix_last;
  logic                      wt_valid;
  logic                      wt_ready;
  input_pipe_pkg::wt_beat_t  wt_data;
  logic                      wt_cin_last;
  logic                      wt_first;
  logic                      image_done;

  pixel_fifo u_pixel_fifo (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_pix_valid),
    .o_s_ready (o_s_pix_ready),
    .i_s_data  (i_s_pix_data),
    .i_s_last  (i_s_pix_last),
    .o_m_valid (pix_valid),
    .i_m_ready (pix_ready),
    .o_m_data  (pix_data),
    .o_m_last  (pix_last)
  );

  weight_rotator u_weight_rotator (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_s_valid    (i_s_wt_valid),
    .o_s_ready    (o_s_wt_ready),
    .i_s_data     (i_s_wt_data),
    .i_s_last     (i_s_wt_last),
    .o_m_valid    (wt_valid),
    .i_m_ready    (wt_ready),
    .o_m_data     (wt_data),
    .o_m_cin_last (wt_cin_last),
    .o_m_first    (wt_first),
    .i_image_done (image_done)
  );

  beat_joiner u_beat_joiner (
    .aclk          (aclk),
    .i_rst_n       (i_rst_n),
    .i_pix_valid   (pix_valid),
    .o_pix_ready   (pix_ready),
    .i_pix_data    (pix_data),
    .i_pix_last    (pix_last),
    .i_wt_valid    (wt_valid),
    .o_wt_ready    (wt_ready),
    .i_wt_data     (wt_data),
    .i_wt_cin_last (wt_cin_last),
    .i_wt_first    (wt_first),
    .o_image_done  (image_done),
    .o_m_valid     (o_m_valid),
    .i_m_ready     (i_m_ready),
    .o_m_pix       (o_m_pix),
    .o_m_wt        (o_m_wt),
    .o_m_user      (o_m_user),
    .o_m_last      (o_m_last)
  );

endmodule

// ==== hdl/beat_joiner.sv ====
`timescale 1ns/1ps

module beat_joiner (
  input  logic                      aclk,
  input  logic                      i_rst_n,
  input  logic                      i_pix_valid,
  output logic                      o_pix_ready,
  input  input_pipe_pkg::pix_beat_t i_pix_data,
  input  logic                      i_pix_last,
  input  logic                      i_wt_valid,
  output logic                      o_wt_ready,
  input  input_pipe_pkg::wt_beat_t  i_wt_data,
  input  logic                      i_wt_cin_last,
  input  logic                      i_wt_first,
  output logic                      o_image_done,
  output logic                      o_m_valid,
  input  logic                      i_m_ready,
  output input_pipe_pkg::pix_beat_t o_m_pix,
  output input_pipe_pkg::wt_beat_t  o_m_wt,
  output input_pipe_pkg::tuser_t    o_m_user,
  output logic                      o_m_last
);

  logic                   load;
  logic                   m_valid_q;
  input_pipe_pkg::tuser_t user_d;

  // Both sides meet and the output slot is free or draining.
  assign load = i_pix_valid && i_wt_valid && (!m_valid_q || i_m_ready);

  assign o_pix_ready  = load;
  assign o_wt_ready   = load;
  assign o_image_done = load && i_pix_last;  // Rotator leaves REPLAY on this edge.

  always_comb begin
    user_d = '0;
    user_d[input_pipe_pkg::TUSER_CIN_LAST] = i_wt_cin_last;
    user_d[input_pipe_pkg::TUSER_FIRST]    = i_wt_first;
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      m_valid_q <= 1'b0;
    end else if (load) begin
      m_valid_q <= 1'b1;
    end else if (i_m_ready) begin
      m_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      o_m_pix  <= i_pix_data;
      o_m_wt   <= i_wt_data;
      o_m_user <= user_d;
      o_m_last <= i_pix_last;
    end
  end

  assign o_m_valid = m_valid_q;

  a_out_hold: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    o_m_valid && !i_m_ready |=>
      o_m_valid && $stable(o_m_pix) && $stable(o_m_wt) &&
      $stable(o_m_user) && $stable(o_m_last)
  );

endmodule

// ==== hdl/input_pipe_pkg.sv ====
`include "input_pipe_macros.svh"

package input_pipe_pkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;

  // Word 0 sits in the low bits.
  typedef word_t [`UNITS-1:0] pix_beat_t;
  typedef word_t [`CORES-1:0] wt_beat_t;

  typedef logic [`BITS_CIN-1:0] cin_t;

  // Side-band to the convolution cores.
  typedef logic [1:0] tuser_t;

  localparam int unsigned TUSER_CIN_LAST = 0;  // Beat ends a channel group.
  localparam int unsigned TUSER_FIRST    = 1;  // First beat of an image.

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    REPLAY
  } rot_state_t;

endpackage

// ==== hdl/pixel_fifo.sv ====
`timescale 1ns/1ps
`include "input_pipe_macros.svh"

module pixel_fifo (
  input  logic                      aclk,
  input  logic                      i_rst_n,
  input  logic                      i_s_valid,
  output logic                      o_s_ready,
  input  input_pipe_pkg::pix_beat_t i_s_data,
  input  logic                      i_s_last,
  output logic                      o_m_valid,
  input  logic                      i_m_ready,
  output input_pipe_pkg::pix_beat_t o_m_data,
  output logic                      o_m_last
);

  localparam int unsigned DEPTH    = `PIX_FIFO_DEPTH;
  localparam int unsigned PTR_BITS = $clog2(DEPTH);
  localparam int unsigned CNT_BITS = $clog2(DEPTH + 1);

  input_pipe_pkg::pix_beat_t mem_data [DEPTH];
  logic                      mem_last [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_next;
  logic                ready_q;
  logic                push;
  logic                pop;

  assign push = i_s_valid && ready_q;
  assign pop  = o_m_valid && i_m_ready;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      ready_q <= 1'b0;
    end else begin
      count   <= count_next;
      ready_q <= (count_next != CNT_BITS'(DEPTH));  // Room for one more.
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem_data[wr_ptr] <= i_s_data;
      mem_last[wr_ptr] <= i_s_last;
    end
  end

  assign o_s_ready = ready_q;
  assign o_m_valid = (count != '0);
  assign o_m_data  = mem_data[rd_ptr];  // Head entry, shown as soon as written.
  assign o_m_last  = mem_last[rd_ptr];

  a_count_bound: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    count <= CNT_BITS'(DEPTH)
  );

  // A push into a non-empty FIFO must never land on the head slot.
  a_head_steady: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    o_m_valid && !i_m_ready |=> $stable(o_m_data) && $stable(o_m_last)
  );

endmodule

// ==== hdl/weight_rotator.sv ====
`timescale 1ns/1ps
`include "input_pipe_macros.svh"

module weight_rotator (
  input  logic                     aclk,
  input  logic                     i_rst_n,
  input  logic                     i_s_valid,
  output logic                     o_s_ready,
  input  input_pipe_pkg::wt_beat_t i_s_data,
  input  logic                     i_s_last,
  output logic                     o_m_valid,
  input  logic                     i_m_ready,
  output input_pipe_pkg::wt_beat_t o_m_data,
  output logic                     o_m_cin_last,
  output logic                     o_m_first,
  input  logic                     i_image_done
);

  localparam int unsigned IDX_BITS = $clog2(`CIN_MAX);

  input_pipe_pkg::rot_state_t state;
  input_pipe_pkg::rot_state_t state_d;
  input_pipe_pkg::wt_beat_t   wt_mem [`CIN_MAX];
  input_pipe_pkg::cin_t       cin_q;
  input_pipe_pkg::cin_t       cin_top;
  input_pipe_pkg::cin_t       cin_cfg;
  input_pipe_pkg::cin_t       wr_idx;
  input_pipe_pkg::cin_t       rd_idx;
  logic                       first_q;
  logic                       ready_q;
  logic                       s_fire;
  logic                       m_fire;

  assign s_fire  = i_s_valid && ready_q;
  assign m_fire  = o_m_valid && i_m_ready;
  assign cin_top = cin_q - 1'b1;  // Last channel index.
  assign cin_cfg = i_s_data[0][`BITS_CIN-1:0];

  always_comb begin
    state_d = state;
    case (state)
      input_pipe_pkg::IDLE: begin
        if (s_fire) begin
          state_d = input_pipe_pkg::LOAD;
        end
      end
      input_pipe_pkg::LOAD: begin
        if (s_fire && i_s_last) begin
          state_d = input_pipe_pkg::REPLAY;
        end
      end
      input_pipe_pkg::REPLAY: begin
        if (i_image_done) begin
          state_d = input_pipe_pkg::IDLE;
        end
      end
      default: begin
        state_d = input_pipe_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state   <= input_pipe_pkg::IDLE;
      ready_q <= 1'b0;
      first_q <= 1'b0;
      cin_q   <= '0;
      wr_idx  <= '0;
      rd_idx  <= '0;
    end else begin
      state   <= state_d;
      ready_q <= (state_d != input_pipe_pkg::REPLAY);  // Takes weights until loaded.
      case (state)
        input_pipe_pkg::IDLE: begin
          if (s_fire) begin
            cin_q  <= cin_cfg;  // Config beat.
            wr_idx <= '0;
          end
        end
        input_pipe_pkg::LOAD: begin
          if (s_fire) begin
            wr_idx <= wr_idx + 1'b1;
            if (i_s_last) begin
              rd_idx  <= '0;
              first_q <= 1'b1;
            end
          end
        end
        input_pipe_pkg::REPLAY: begin
          if (m_fire) begin
            rd_idx  <= o_m_cin_last ? '0 : rd_idx + 1'b1;
            first_q <= 1'b0;
          end
        end
        default: begin
          first_q <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == input_pipe_pkg::LOAD && s_fire) begin
      wt_mem[wr_idx[IDX_BITS-1:0]] <= i_s_data;
    end
  end

  assign o_s_ready    = ready_q;
  assign o_m_valid    = (state == input_pipe_pkg::REPLAY);
  assign o_m_data     = wt_mem[rd_idx[IDX_BITS-1:0]];
  assign o_m_cin_last = (rd_idx == cin_top);
  assign o_m_first    = first_q;

  a_cin_range: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (state == input_pipe_pkg::IDLE) && s_fire |->
      (cin_cfg != '0) && (cin_cfg <= input_pipe_pkg::cin_t'(`CIN_MAX))
  );

  // Packet length must agree with the cin of its config beat.
  a_last_on_cin: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (state == input_pipe_pkg::LOAD) && s_fire |-> (i_s_last == (wr_idx == cin_top))
  );

  // The image ends on the beat that wraps the index, so groups stay whole.
  a_done_on_wrap: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    i_image_done |-> m_fire && o_m_cin_last
  );

endmodule

// ==== include/input_pipe_macros.svh ====
`ifndef INPUT_PIPE_MACROS_SVH
`define INPUT_PIPE_MACROS_SVH

// Bits in one pixel or weight word.
`define WORD_WIDTH 8

// Pixel words per beat, one per convolution unit.
`define UNITS 2

// Weight words per beat, one per convolution core.
`define CORES 2

// Pixel FIFO entries.
`define PIX_FIFO_DEPTH 4

// Largest input channel count of a layer.
`define CIN_MAX 8

// Holds a channel count from 1 to CIN_MAX.
`define BITS_CIN 4

`endif
